// ==== common/uart_cfg_pkg.sv ====
`default_nettype none

package uart_cfg_pkg;

    // ------------------------------------------------------------------------
    // Line rate and clock
    // ------------------------------------------------------------------------
    localparam int BAUD        = 115200;    // Bits per second, about 8.68 us per bit
    localparam int SOURCE_FREQ = 25000000;  // 25 MHz system clock, 40 ns period

    // ------------------------------------------------------------------------
    // Phase accumulator
    // ------------------------------------------------------------------------
    // The accumulator is ACC_WIDTH bits plus one carry bit. The carry bit is
    // the bit tick, the two bits below it give half and quarter ticks.
    localparam int ACC_WIDTH = 16;

    // Increment per clock, rounded to nearest instead of truncated
    // (plain truncation would give 301 here, rounding gives 302)
    localparam logic [ACC_WIDTH:0] COUNT_INC = (ACC_WIDTH + 1)'(
        ((BAUD << (ACC_WIDTH - 4)) + (SOURCE_FREQ >> 5)) / (SOURCE_FREQ >> 4)
    );

    // Approximate clock cycles in one bit period, 217 for the defaults
    localparam int BIT_CYCLES = (1 << ACC_WIDTH) / int'(COUNT_INC);

    // Ratio check for the defaults:
    //   25e6 / 115200          = 217.01 cycles per bit
    //   65536 / 302            = 217.0
    // so the accumulator error stays well under one percent

endpackage : uart_cfg_pkg

`default_nettype wire

// ==== common/uart_types_pkg.sv ====
`default_nettype none

package uart_types_pkg;

    // ------------------------------------------------------------------------
    // Engine states
    // ------------------------------------------------------------------------
    typedef enum logic [2:0] {
        RX_IDLE,    // Line idle, waiting for a start edge
        RX_START,   // Half bit wait into the start bit
        RX_HALF,    // One period more to reach the first data bit middle
        RX_DATA,    // Sampling the remaining data bits
        RX_STOP     // Waiting for a high stop level
    } rx_state_t;

    typedef enum logic [1:0] {
        TX_IDLE,    // Line high, ready for a request
        TX_START,   // Driving the low start bit
        TX_DATA,    // Shifting data out, LSB first
        TX_STOP     // Driving the high stop bit
    } tx_state_t;

    // ------------------------------------------------------------------------
    // Parallel side payloads
    // ------------------------------------------------------------------------
    // Transmit request, start is a one cycle strobe
    typedef struct packed {
        logic       start;  // Accepted only while the transmitter is idle
        logic [7:0] data;   // Byte to send
    } tx_req_t;

    // Receive result, valid pulses once per completed frame
    typedef struct packed {
        logic       valid;  // One cycle strobe
        logic [7:0] data;   // Held until the next frame completes
    } rx_result_t;

    // Both structs are 9 bits wide

endpackage : uart_types_pkg

`default_nettype wire

// ==== src/cdc_sync.sv ====
`default_nettype none

module cdc_sync (
    input  logic sourceClk,     // System clock
    input  logic arst_n,        // Async reset, active low
    input  logic async_in,      // Raw serial line
    output logic sync_out,      // Line in the clock domain, two cycles late
    output logic rise,          // One cycle pulse on a low to high change
    output logic fall           // One cycle pulse on a high to low change
);

    // ------------------------------------------------------------------------
    // Synchronizer chain
    // ------------------------------------------------------------------------
    logic meta_q;       // First stage, may go metastable
    logic sync_q;       // Second stage, safe to use
    logic hist_q;       // Previous synchronized level

    // All stages idle high like the line itself
    // so no start edge is seen when reset is released
    always_ff @(posedge sourceClk or negedge arst_n) begin
        if (!arst_n) begin
            meta_q <= 1'b1;
            sync_q <= 1'b1;
            hist_q <= 1'b1;
        end else begin
            meta_q <= async_in;
            sync_q <= meta_q;
            hist_q <= sync_q;
        end
    end

    assign sync_out = sync_q;

    // Edge pulses, high in the first cycle of the new level
    assign rise = sync_q & ~hist_q;
    assign fall = ~sync_q & hist_q;   // Start bit detect

endmodule : cdc_sync

`default_nettype wire

// ==== src/baud_accum.sv ====
`default_nettype none

module baud_accum (
    input  logic sourceClk,     // System clock
    input  logic arst_n,        // Async reset, active low
    input  logic clear,         // Return the count to zero on the next edge
    output logic tick_full,     // One bit period has elapsed
    output logic tick_half,     // Half a bit period has elapsed
    output logic tick_quarter   // Quarter bit period bit
);

    import uart_cfg_pkg::*;

    // ------------------------------------------------------------------------
    // Phase accumulator
    // ------------------------------------------------------------------------
    // One extra bit on top catches the rollover
    logic [ACC_WIDTH:0] count;

    always_ff @(posedge sourceClk or negedge arst_n) begin
        if (!arst_n) begin
            count <= '0;
        end else if (clear) begin
            count <= '0;                    // Owner restarts the period
        end else begin
            count <= count + COUNT_INC;     // Free running add
        end
    end

    // Ticks come straight off the top three bits
    // and are valid in the same cycle as the count
    assign tick_full    = count[ACC_WIDTH];
    assign tick_half    = count[ACC_WIDTH-1];
    assign tick_quarter = count[ACC_WIDTH-2];

    // The owner clears on every tick it acts on, so the carry bit
    // is normally seen high for a single cycle only

endmodule : baud_accum

`default_nettype wire

// ==== rx/uart_rx.sv ====
`default_nettype none

module uart_rx (
    input  logic                       sourceClk,   // System clock
    input  logic                       arst_n,      // Async reset, active low
    input  logic                       rx_sync,     // Synchronized serial line
    input  logic                       rx_fall,     // Falling edge of rx_sync
    output uart_types_pkg::rx_result_t result       // Byte and completion strobe
);

    import uart_types_pkg::*;

    // ------------------------------------------------------------------------
    // Declarations
    // ------------------------------------------------------------------------
    rx_state_t  state;
    rx_state_t  state_nxt;

    logic       acc_clear;      // Restart the baud period
    logic       tick_full;
    logic       tick_half;
    logic       tick_quarter;

    logic       shift_en;       // Take one data sample
    logic       cnt_load;       // First sample taken, seven to go
    logic       cnt_dec;        // Count down one data bit
    logic       done;           // Stop level seen, frame complete

    logic [2:0] bit_cnt;        // Data bits still to come
    logic [7:0] shift_q;        // Assembles the byte, LSB arrives first
    logic [7:0] data_q;         // Last completed byte
    logic       valid_q;

    // Baud timing for this engine only
    baud_accum u_baud_accum (
        .sourceClk    (sourceClk),
        .arst_n       (arst_n),
        .clear        (acc_clear),
        .tick_full    (tick_full),
        .tick_half    (tick_half),
        .tick_quarter (tick_quarter)
    );

    // ------------------------------------------------------------------------
    // Next state and datapath controls
    // ------------------------------------------------------------------------
    always_comb begin
        state_nxt = state;
        acc_clear = 1'b0;
        shift_en  = 1'b0;
        cnt_load  = 1'b0;
        cnt_dec   = 1'b0;
        done      = 1'b0;

        case (state)
            RX_IDLE: begin
                acc_clear = 1'b1;               // Hold the count at zero
                if (rx_fall) begin
                    state_nxt = RX_START;       // Start bit edge
                end
            end

            RX_START: begin
                if (tick_half) begin            // Now near the start bit middle
                    state_nxt = RX_HALF;
                    acc_clear = 1'b1;
                end
            end

            RX_HALF: begin
                if (tick_full) begin            // Middle of data bit 0
                    state_nxt = RX_DATA;
                    acc_clear = 1'b1;
                    shift_en  = 1'b1;
                    cnt_load  = 1'b1;
                end
            end

            RX_DATA: begin
                if (tick_full) begin
                    acc_clear = 1'b1;
                    cnt_dec   = 1'b1;
                    if (bit_cnt == 3'd0) begin
                        state_nxt = RX_STOP;    // Now in the stop bit
                    end else begin
                        shift_en = 1'b1;        // Bits 1 to 7
                    end
                end
            end

            RX_STOP: begin
                // Wait until the line is high at a quarter tick
                if (tick_quarter && rx_sync) begin
                    state_nxt = RX_IDLE;
                    acc_clear = 1'b1;
                    done      = 1'b1;
                end
            end

            default: begin
                state_nxt = RX_IDLE;
                acc_clear = 1'b1;
            end
        endcase
    end

    // ------------------------------------------------------------------------
    // Registers
    // ------------------------------------------------------------------------
    always_ff @(posedge sourceClk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= RX_IDLE;
            bit_cnt <= '0;
            valid_q <= 1'b0;
        end else begin
            state   <= state_nxt;
            valid_q <= done;                    // Single cycle strobe
            if (cnt_load) begin
                bit_cnt <= 3'd7;
            end else if (cnt_dec) begin
                bit_cnt <= bit_cnt - 3'd1;
            end
        end
    end

    // Payload path
    always_ff @(posedge sourceClk) begin
        if (shift_en) begin
            shift_q <= {rx_sync, shift_q[7:1]};  // New bit enters at the top
        end
        if (done) begin
            data_q <= shift_q;                   // Stable until next frame
        end
    end

    assign result.valid = valid_q;
    assign result.data  = data_q;

endmodule : uart_rx

`default_nettype wire

// ==== tx/uart_tx.sv ====
`default_nettype none

module uart_tx (
    input  logic                    sourceClk,  // System clock
    input  logic                    arst_n,     // Async reset, active low
    input  uart_types_pkg::tx_req_t req,        // Start strobe and byte
    output logic                    tx_out,     // Serial line, idles high
    output logic                    busy        // Frame in progress
);

    import uart_types_pkg::*;

    // ------------------------------------------------------------------------
    // Declarations
    // ------------------------------------------------------------------------
    tx_state_t  state;

    logic       accept;         // Start strobe taken this cycle
    logic       acc_clear;
    logic       tick_full;      // End of the current bit
    logic       shift_en;       // Put the next data bit on the line
    logic       last_bit;       // Bit 7 is on the line

    logic [2:0] bit_cnt;        // Index of the data bit on the line
    logic [7:0] shift_q;        // Bits not yet sent, next one at bit 0

    // Only the full tick matters here
    baud_accum u_baud_accum (
        .sourceClk    (sourceClk),
        .arst_n       (arst_n),
        .clear        (acc_clear),
        .tick_full    (tick_full),
        .tick_half    (),
        .tick_quarter ()
    );

    // ------------------------------------------------------------------------
    // Controls
    // ------------------------------------------------------------------------
    assign busy      = (state != TX_IDLE);
    assign accept    = req.start && !busy;          // Ignored while busy
    assign acc_clear = !busy || tick_full;          // Fresh period per bit
    assign last_bit  = (bit_cnt == 3'd7);

    // Shift after the start bit and after bits 0 to 6
    assign shift_en  = tick_full &&
                       ((state == TX_START) || ((state == TX_DATA) && !last_bit));

    // ------------------------------------------------------------------------
    // Frame sequencer
    // ------------------------------------------------------------------------
    always_ff @(posedge sourceClk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= TX_IDLE;
            tx_out  <= 1'b1;                        // Idle line level
            bit_cnt <= '0;
        end else begin
            case (state)
                TX_IDLE: begin
                    if (accept) begin
                        state  <= TX_START;
                        tx_out <= 1'b0;             // Start bit
                    end
                end

                TX_START: begin
                    if (tick_full) begin
                        state   <= TX_DATA;
                        bit_cnt <= '0;
                    end
                end

                TX_DATA: begin
                    if (tick_full) begin
                        if (last_bit) begin
                            state  <= TX_STOP;
                            tx_out <= 1'b1;         // Stop bit
                        end else begin
                            bit_cnt <= bit_cnt + 3'd1;
                        end
                    end
                end

                TX_STOP: begin
                    if (tick_full) begin
                        state <= TX_IDLE;           // Busy drops next cycle
                    end
                end

                default: begin
                    state  <= TX_IDLE;
                    tx_out <= 1'b1;
                end
            endcase

            if (shift_en) begin
                tx_out <= shift_q[0];               // LSB first
            end
        end
    end

    // Byte store
    always_ff @(posedge sourceClk) begin
        if (accept) begin
            shift_q <= req.data;
        end else if (shift_en) begin
            shift_q <= {1'b0, shift_q[7:1]};
        end
    end

endmodule : uart_tx

`default_nettype wire

// ==== src/uart_top.sv ====
`default_nettype none

module uart_top (
    input  logic                       sourceClk,   // System clock
    input  logic                       arst_n,      // Async reset, active low
    input  logic                       rx_in,       // Serial input, asynchronous
    input  uart_types_pkg::tx_req_t    tx_req,      // Transmit strobe and byte
    output logic                       tx_out,      // Serial output
    output logic                       tx_busy,     // Transmit in progress
    output uart_types_pkg::rx_result_t rx_result    // Received byte and strobe
);

    // ------------------------------------------------------------------------
    // Receive path
    // ------------------------------------------------------------------------
    logic rx_sync;      // Line after the synchronizer
    logic rx_fall;      // Start edge candidate

    cdc_sync u_cdc_sync (
        .sourceClk (sourceClk),
        .arst_n    (arst_n),
        .async_in  (rx_in),
        .sync_out  (rx_sync),
        .rise      (),              // Receiver only needs the falling edge
        .fall      (rx_fall)
    );

    // Owns its own baud accumulator
    uart_rx u_uart_rx (
        .sourceClk (sourceClk),
        .arst_n    (arst_n),
        .rx_sync   (rx_sync),
        .rx_fall   (rx_fall),
        .result    (rx_result)
    );

    // ------------------------------------------------------------------------
    // Transmit path
    // ------------------------------------------------------------------------
    // Line goes low one cycle after an accepted start strobe
    uart_tx u_uart_tx (
        .sourceClk (sourceClk),
        .arst_n    (arst_n),
        .req       (tx_req),
        .tx_out    (tx_out),
        .busy      (tx_busy)
    );

endmodule : uart_top

`default_nettype wire

// ==== test/tb_uart_tasks.svh ====
`ifndef TB_UART_TASKS_SVH
`define TB_UART_TASKS_SVH

// ----------------------------------------------------------------------------
// Timing and random bytes
// ----------------------------------------------------------------------------
// Inputs change one unit after the rising edge
task automatic advance_cycles(input int n);
    repeat (n) @(posedge sourceClk);
    #1;
endtask

function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
endfunction

// ----------------------------------------------------------------------------
// Transmit side
// ----------------------------------------------------------------------------
task automatic send_byte(input logic [7:0] data);
    while (tx_busy) begin
        advance_cycles(1);                  // Sent as soon as busy drops
    end
    tx_req.start = 1'b1;
    tx_req.data  = data;
    sb_q.push_back(data);
    frames_sent++;
    advance_cycles(1);
    tx_req.start = 1'b0;
endtask

// Second strobe lands mid frame and must be dropped
task automatic send_with_ignored_start(input logic [7:0] first, input logic [7:0] second);
    send_byte(first);
    advance_cycles(3 * BIT_CYCLES);
    tx_req.start = 1'b1;
    tx_req.data  = second;                  // Not on the scoreboard
    advance_cycles(1);
    tx_req.start = 1'b0;
endtask

// ----------------------------------------------------------------------------
// Receive side
// ----------------------------------------------------------------------------
task automatic wait_rx_drain();
    int waited;
    waited = 0;
    while (sb_q.size() != 0 && waited < 2 * FRAME_CYCLES) begin
        advance_cycles(1);
        waited++;
    end
    drain_done: assert (sb_q.size() == 0) else begin
        protocol_errors++;
        $display("Receiver never delivered %0d expected bytes", sb_q.size());
    end
endtask

// One 8N1 frame on the bit-bang line, stop optionally held low first
task automatic bang_frame(input logic [7:0] data, input int low_stop_bits);
    int pulses_before;
    int waited;
    sb_q.push_back(data);
    frames_sent++;
    bb_line = 1'b0;                         // Start bit
    advance_cycles(BIT_CYCLES);
    for (int i = 0; i < 8; i++) begin
        bb_line = data[i];                  // LSB first
        advance_cycles(BIT_CYCLES);
    end
    if (low_stop_bits > 0) begin
        stop_held = 1'b1;
        bb_line   = 1'b0;
        advance_cycles(low_stop_bits * BIT_CYCLES);
    end
    pulses_before = valid_count;
    stop_held     = 1'b0;
    bb_line       = 1'b1;                   // Stop level
    waited        = 0;
    while (valid_count == pulses_before && waited < BIT_CYCLES) begin
        advance_cycles(1);
        waited++;
    end
    arrival: assert (valid_count != pulses_before) else begin
        protocol_errors++;
        $display("No byte within one bit period after the line went high");
    end
    advance_cycles(BIT_CYCLES);             // Rest of stop plus idle
    single_pulse: assert (valid_count <= pulses_before + 1) else begin
        protocol_errors++;
        $display("More than one valid pulse for a single frame");
    end
endtask

`endif

// ==== test/tb_uart_top.sv ====
`default_nettype none

module tb_uart_top;

    import uart_cfg_pkg::*;
    import uart_types_pkg::*;

    // ----------------------------------------------------------------------------
    // Run limits
    // ----------------------------------------------------------------------------
    localparam int RESET_CYCLES   = 16;
    localparam int FRAME_CYCLES   = 12 * BIT_CYCLES;            // Frame plus slack
    localparam int TIMEOUT_CYCLES = 30 * FRAME_CYCLES + 2000;   // 29 frames sent, margin on top
    localparam int BUSY_MIN       = 10 * BIT_CYCLES;            // Ten bits per frame
    localparam int BUSY_MAX       = 10 * BIT_CYCLES + 40;       // Accumulator rounds up a little

    logic        sourceClk;
    logic        arst_n;
    logic        rx_in;
    tx_req_t     tx_req;
    logic        tx_out;
    logic        tx_busy;
    rx_result_t  rx_result;

    logic        loopback;          // High routes tx_out back to rx_in
    logic        bb_line;           // Line driven by the bit-bang tasks
    logic        stop_held;         // Stop level forced low on the bit-bang line
    logic [31:0] lcg_state;
    logic [7:0]  sb_q[$];           // Expected bytes, oldest first
    logic [7:0]  exp_head;
    logic        exp_empty;
    int          valid_count;       // Valid pulses seen
    int          frames_sent;
    int          busy_len;          // Length of the running busy level
    int          last_len;          // Length of the last finished one
    int          cycle_cnt;
    int          mismatch_errors;
    int          protocol_errors;
    rx_state_t   rx_state_dbg;

    assign rx_in        = loopback ? tx_out : bb_line;
    assign rx_state_dbg = u_dut.u_uart_rx.state;

    uart_top u_dut (
        .sourceClk (sourceClk),
        .arst_n    (arst_n),
        .rx_in     (rx_in),
        .tx_req    (tx_req),
        .tx_out    (tx_out),
        .tx_busy   (tx_busy),
        .rx_result (rx_result)
    );

    initial begin
        sourceClk = 1'b0;
        forever #2 sourceClk = ~sourceClk;
    end

    `include "tb_uart_tasks.svh"

    // Scoreboard and busy length, updated away from the rising edge
    always @(negedge sourceClk) begin
        if (rx_result.valid) begin
            valid_count++;
            if (sb_q.size() > 0) begin
                void'(sb_q.pop_front());    // exp_head keeps it for the next edge
            end
        end else begin
            exp_empty = (sb_q.size() == 0);
            exp_head  = exp_empty ? 8'h00 : sb_q[0];
        end
        if (tx_busy) begin
            busy_len++;
        end else if (busy_len != 0) begin
            last_len = busy_len;            // Frame just ended
            busy_len = 0;
        end
    end

    // ----------------------------------------------------------------------------
    // Checks
    // ----------------------------------------------------------------------------
    // First edge is skipped, the flops only take reset there
    reset_values: assert property (@(posedge sourceClk)
        (!arst_n && cycle_cnt > 1) |-> (tx_out && !tx_busy && !rx_result.valid))
        else begin
            protocol_errors++;
            $display("Outputs left their reset values while reset was held");
        end

    // Outputs after the first active edge out of reset
    leave_reset: assert property (@(posedge sourceClk)
        $rose(arst_n) |=> (tx_out && !tx_busy && !rx_result.valid))
        else begin
            protocol_errors++;
            $display("Outputs were not idle right after reset");
        end

    no_early_valid: assert property (@(posedge sourceClk)
        (cycle_cnt < RESET_CYCLES + 9 * BIT_CYCLES) |-> !rx_result.valid)
        else begin
            protocol_errors++;
            $display("A byte was received before any frame could arrive");
        end

    idle_line_high: assert property (@(posedge sourceClk) disable iff (!arst_n)
        !tx_busy |-> tx_out)
        else begin
            protocol_errors++;
            $display("Transmit line was low while the transmitter was idle");
        end

    start_accepted: assert property (@(posedge sourceClk) disable iff (!arst_n)
        (tx_req.start && !tx_busy) |=> (tx_busy && !tx_out))
        else begin
            protocol_errors++;
            $display("Start strobe did not raise busy and the start bit");
        end

    busy_from_start: assert property (@(posedge sourceClk) disable iff (!arst_n)
        $rose(tx_busy) |-> $past(tx_req.start))
        else begin
            protocol_errors++;
            $display("Busy rose without a start strobe");
        end

    busy_too_long: assert property (@(posedge sourceClk) disable iff (!arst_n)
        tx_busy |-> (busy_len <= BUSY_MAX))
        else begin
            protocol_errors++;
            $display("Busy stayed high longer than one frame");
        end

    busy_too_short: assert property (@(posedge sourceClk) disable iff (!arst_n)
        $fell(tx_busy) |-> (last_len >= BUSY_MIN))
        else begin
            protocol_errors++;
            $display("Busy dropped before the frame was over, after %0d cycles", last_len);
        end

    rx_data: assert property (@(posedge sourceClk) disable iff (!arst_n)
        (rx_result.valid && !exp_empty) |-> (rx_result.data == exp_head))
        else begin
            mismatch_errors++;
            $display("Mismatch rx_result.data: expected 0x%02h, actual 0x%02h",
                     $sampled(exp_head), $sampled(rx_result.data));
        end

    rx_unexpected: assert property (@(posedge sourceClk) disable iff (!arst_n)
        rx_result.valid |-> !exp_empty)
        else begin
            protocol_errors++;
            $display("A byte arrived that was never sent");
        end

    pulse_width: assert property (@(posedge sourceClk) disable iff (!arst_n)
        rx_result.valid |=> !rx_result.valid)
        else begin
            protocol_errors++;
            $display("Valid stayed high for two cycles in a row");
        end

    no_valid_low_stop: assert property (@(posedge sourceClk) disable iff (!arst_n)
        stop_held |-> !rx_result.valid)
        else begin
            protocol_errors++;
            $display("Valid pulsed while the stop level was held low");
        end

    // Hang guard
    always @(posedge sourceClk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt == TIMEOUT_CYCLES) begin
            $display("Timeout, the run hung after %0d cycles with the receiver in %s",
                     cycle_cnt, rx_state_dbg.name());
            $display("Errors: mismatch %0d, protocol %0d", mismatch_errors, protocol_errors);
            $display("Simulation failed");
            $finish;
        end
    end

    // ----------------------------------------------------------------------------
    // Stimulus
    // ----------------------------------------------------------------------------
    initial begin
        arst_n          = 1'b0;
        loopback        = 1'b1;
        bb_line         = 1'b1;             // Idle line level
        stop_held       = 1'b0;
        tx_req          = '0;
        lcg_state       = 32'hfdd7_f664;
        exp_head        = 8'h00;
        exp_empty       = 1'b1;
        valid_count     = 0;
        frames_sent     = 0;
        busy_len        = 0;
        last_len        = 0;
        cycle_cnt       = 0;
        mismatch_errors = 0;
        protocol_errors = 0;

        advance_cycles(RESET_CYCLES);
        arst_n = 1'b1;
        advance_cycles(2);

        send_byte(8'h00);                   // Fixed loopback set
        send_byte(8'hff);
        send_byte(8'h55);
        send_byte(8'ha5);
        wait_rx_drain();

        send_with_ignored_start(8'h3c, 8'hc3);
        wait_rx_drain();

        for (int i = 0; i < 20; i++) begin
            lcg_state = lcg_next(lcg_state);
            send_byte(lcg_state[23:16]);    // Upper bits have the longer period
        end
        wait_rx_drain();

        while (tx_busy) begin
            advance_cycles(1);
        end
        loopback = 1'b0;                    // Both lines idle high here
        advance_cycles(BIT_CYCLES);

        bang_frame(8'h96, 0);
        bang_frame(8'h01, 0);
        bang_frame(8'he7, 3);               // Stop low for three bits
        bang_frame(8'h5a, 0);
        wait_rx_drain();

        end_counts: assert (valid_count == frames_sent && sb_q.size() == 0) else begin
            protocol_errors++;
            $display("Received %0d bytes, but %0d frames were sent", valid_count, frames_sent);
        end

        $display("Errors: mismatch %0d, protocol %0d", mismatch_errors, protocol_errors);
        if (mismatch_errors + protocol_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule : tb_uart_top

`default_nettype wire

// ==== uart_top.f ====
common/uart_cfg_pkg.sv
common/uart_types_pkg.sv
src/cdc_sync.sv
src/baud_accum.sv
rx/uart_rx.sv
tx/uart_tx.sv
src/uart_top.sv
+incdir+test
test/tb_uart_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the UART testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_uart_top \
    -f uart_top.f \
    -o Vtb_uart_top

out=$(./obj_dir/Vtb_uart_top)
echo "$out"

if echo "$out" | grep -qx "Simulation passed"; then
    exit 0
fi
exit 1
